// File: verif/bsx_input.txt
# name op use_bsx addr data expected, all but name and op in hex
# W write, R read, P pgm (data set mask, expected reset mask), G regs_out, O {ovr, writable}
cart_w3      W 1 035000 80 0000
cart_stage   G 1 035000 00 0100
cart_rd3     R 1 035000 00 0000
cart_rd8     R 1 085000 00 0080
cart_commit  W 1 0E5000 80 0000
cart_live    G 1 0E5000 00 4108
cart_rd3b    R 1 035000 00 0080
cart_rd14    R 1 0E5000 00 0080
cart_rdf     R 1 0F5000 00 0000
pgm_set      P 1 000000 06 0000
pgm_set_g    G 1 000000 00 410C
pgm_both     P 1 000000 11 0081
pgm_both_g   G 1 000000 00 402C
base_def0b   R 1 00218B 00 009F
base_def0c   R 1 00218C 00 0010
base_def17   R 1 002197 00 00FF
base_def19   R 1 002199 00 0001
base_def08   R 1 002188 00 0000
base_w08     W 1 002188 5A 0000
base_rd08    R 1 002188 00 005A
base_w13     W 1 002193 FF 0000
base_rd13    R 1 002193 00 003F
base_w0e     W 1 00218E 40 0000
base_half1   W 1 00218F 33 0000
base_rd0e    R 1 00218E 00 00E0
base_rd0f    R 1 00218F 00 0000
base_half2   W 1 00218F 00 0000
base_rd0e2   R 1 00218E 00 0090
strm_clr     W 1 002191 00 0000
strm_00      R 1 002192 00 0000
strm_01      R 1 002192 00 0000
strm_02      R 1 002192 00 0000
strm_03      R 1 002192 00 0000
strm_04      R 1 002192 00 0000
strm_05      R 1 002192 00 0001
strm_06      R 1 002192 00 0001
strm_07      R 1 002192 00 0000
strm_08      R 1 002192 00 0000
strm_09      R 1 002192 00 0000
strm_10      R 1 002192 00 002A
strm_11      R 1 002192 00 001E
strm_12      R 1 002192 00 0012
strm_13      R 1 002192 00 0000
strm_14      R 1 002192 00 0000
strm_15      R 1 002192 00 0000
strm_16      R 1 002192 00 0000
strm_17      R 1 002192 00 0000
strm_wrap    R 1 002192 00 0000
fl_idle      O 1 C05555 00 0000
fl_aa        W 1 C05555 AA 0000
fl_55        W 1 C02AAA 55 0000
fl_a0        W 1 C05555 A0 0000
fl_prg_spc   O 1 C05555 00 0002
fl_prg_wr    O 1 C01234 00 0001
fl_aa2       W 1 C05555 AA 0000
fl_552       W 1 C02AAA 55 0000
fl_70        W 1 C05555 70 0000
fl_sts_wr    O 1 C01234 00 0000
fl_sts_spc   O 1 C05555 00 0002
fl_aa3       W 1 C05555 AA 0000
fl_553       W 1 C02AAA 55 0000
fl_f0        W 1 C05555 F0 0000
fl_rd_mode   O 1 C05555 00 0000
fl_38        W 1 C00000 38 0000
fl_d0        W 1 C00000 D0 0000
fl_sts2      O 1 C00000 00 0002
fl_rd02      R 1 C00002 00 0080
fl_id0       R 1 C0FF00 00 004D
fl_id1       R 1 C0FF01 00 0000
fl_id2       R 1 C0FF02 00 0050
fl_id6       R 1 C0FF06 00 002A
off_ovr_cart O 0 035000 00 0000
off_ovr_base O 0 002188 00 0000
off_stage    W 1 045000 80 0000
off_stage_g  G 1 045000 00 402C
off_commit   W 0 0E5000 80 0000
off_live     G 0 0E5000 00 402C
off_base_w   W 0 002188 11 0000
off_base_rd  R 1 002188 00 005A
on_commit    W 1 0E5000 80 0000
on_live      G 1 0E5000 00 403C

// File: all.f
+incdir+logic
logic/bsx_pkg.sv
logic/strobe_sync.sv
logic/bsx_decode.sv
logic/bsx_cart_regs.sv
logic/bsx_base_regs.sv
logic/bsx_flash_cmd.sv
logic/bsx_read_mux.sv
logic/bsx.sv
verif/bsx_assertions.sv
verif/bsx_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the BS-X register testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=bsx_sim
LOG_FILE=sim.log

if ! verilator --binary --timing --assert -f all.f --top-module bsx_tb \
    -Mdir "$BUILD_DIR" -o "$SIM_BIN"; then
  echo "Verilator build failed"
  exit 1
fi

if ! "./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1; then
  cat "$LOG_FILE"
  echo "Simulation exited with an error"
  exit 1
fi

cat "$LOG_FILE"

if grep -q "TEST PASSED" "$LOG_FILE"; then
  exit 0
else
  echo "Pass message not found in $LOG_FILE"
  exit 1
fi

// File: verif/bsx_tb.sv
`timescale 1ns/1ps
`include "bsx_cfg.svh"

module bsx_tb;

  localparam int NAME_W = 8 * 20;

  logic                   clkin;
  logic                   rst_n;
  logic                   reg_oe;
  logic                   reg_we;
  logic                   pgm_we;
  logic [`BSX_ADDR_W-1:0] snes_addr;
  logic [`BSX_DATA_W-1:0] reg_data_in;
  logic [`BSX_DATA_W-1:0] reg_set_bits;
  logic [`BSX_DATA_W-1:0] reg_reset_bits;
  logic                   use_bsx;
  logic [`BSX_DATA_W-1:0] reg_data_out;
  logic [`BSX_REGS_W-1:0] regs_out;
  logic                   data_ovr;
  logic                   flash_writable;

  // Stimulus table, one entry per data line
  logic [NAME_W-1:0]      name_q [$];
  logic [7:0]             op_q [$];
  logic                   use_q [$];
  logic [`BSX_ADDR_W-1:0] addr_q [$];
  logic [7:0]             data_q [$];
  logic [15:0]            exp_q [$];

  int cycle_cnt = 0;
  int cycle_limit = 0;

  bsx DUT (
    .clkin          (clkin),
    .rst_n          (rst_n),
    .reg_oe         (reg_oe),
    .reg_we         (reg_we),
    .pgm_we         (pgm_we),
    .snes_addr      (snes_addr),
    .reg_data_in    (reg_data_in),
    .reg_set_bits   (reg_set_bits),
    .reg_reset_bits (reg_reset_bits),
    .use_bsx        (use_bsx),
    .reg_data_out   (reg_data_out),
    .regs_out       (regs_out),
    .data_ovr       (data_ovr),
    .flash_writable (flash_writable)
  );

  initial begin
    clkin = 1'b0;
    forever #50 clkin = ~clkin;
  end

  ////////////////////////////////////////////////////////////
  // Failure reporting and checks
  ////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_value(input logic [NAME_W-1:0] name, input logic [15:0] expected,
                             input logic [15:0] actual);
    assert (actual === expected)
      else abort_run($sformatf("MISMATCH %0s expected %h actual %h", name, expected, actual));
  endtask

  always @(posedge clkin) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
      abort_run($sformatf("Timeout after %0d clocks, the tests did not finish", cycle_cnt));
  end

  ////////////////////////////////////////////////////////////
  // Bus operations
  ////////////////////////////////////////////////////////////

  task automatic bus_write(input logic use_en, input logic [`BSX_ADDR_W-1:0] addr,
                           input logic [7:0] data);
    @(posedge clkin);
    use_bsx     <= use_en;
    snes_addr   <= addr;
    reg_data_in <= data;
    reg_we      <= 1'b1;
    repeat (8) @(posedge clkin);
    reg_we <= 1'b0;
    repeat (8) @(posedge clkin);
  endtask

  // oe idles high, the event is its filtered falling edge
  task automatic bus_read(input logic [NAME_W-1:0] name, input logic use_en,
                          input logic [`BSX_ADDR_W-1:0] addr, input logic [7:0] expected);
    @(posedge clkin);
    use_bsx   <= use_en;
    snes_addr <= addr;
    reg_oe    <= 1'b0;
    repeat (10) @(posedge clkin);
    @(negedge clkin);
    check_value(name, {8'h00, expected}, {8'h00, reg_data_out});
    @(posedge clkin);
    reg_oe <= 1'b1;
    repeat (8) @(posedge clkin);
  endtask

  task automatic pgm_pulse(input logic use_en, input logic [`BSX_ADDR_W-1:0] addr,
                           input logic [7:0] set_mask, input logic [7:0] reset_mask);
    @(posedge clkin);
    use_bsx        <= use_en;
    snes_addr      <= addr;
    reg_set_bits   <= set_mask;
    reg_reset_bits <= reset_mask;
    pgm_we         <= 1'b1;
    repeat (8) @(posedge clkin);
    pgm_we <= 1'b0;
    repeat (8) @(posedge clkin);
  endtask

  task automatic check_regs(input logic [NAME_W-1:0] name, input logic [14:0] expected);
    @(posedge clkin);
    @(negedge clkin);
    check_value(name, {1'b0, expected}, {1'b0, regs_out});
  endtask

  task automatic check_override(input logic [NAME_W-1:0] name, input logic use_en,
                                input logic [`BSX_ADDR_W-1:0] addr, input logic [1:0] expected);
    @(posedge clkin);
    use_bsx   <= use_en;
    snes_addr <= addr;
    @(negedge clkin);
    check_value(name, {14'h0, expected}, {14'h0, data_ovr, flash_writable});
  endtask

  task automatic load_stimulus();
    int                fd;
    int                got;
    int                fields;
    string             line;
    logic [NAME_W-1:0] f_name;
    logic [7:0]        f_op;
    logic [31:0]       f_use;
    logic [31:0]       f_addr;
    logic [31:0]       f_data;
    logic [31:0]       f_exp;
    fd = $fopen("verif/bsx_input.txt", "r");
    if (fd == 0) begin
      abort_run("Could not open the stimulus file verif/bsx_input.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        got = $fgets(line, fd);
        if (got == 0 || line.getc(0) == "#")
          continue;
        fields = $sscanf(line, "%s %s %h %h %h %h",
                         f_name, f_op, f_use, f_addr, f_data, f_exp);
        if (fields == 6) begin
          name_q.push_back(f_name);
          op_q.push_back(f_op);
          use_q.push_back(f_use[0]);
          addr_q.push_back(f_addr[`BSX_ADDR_W-1:0]);
          data_q.push_back(f_data[7:0]);
          exp_q.push_back(f_exp[15:0]);
        end
      end
      $fclose(fd);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    rst_n          = 1'b0;
    reg_oe         = 1'b1;
    reg_we         = 1'b0;
    pgm_we         = 1'b0;
    snes_addr      = '0;
    reg_data_in    = '0;
    reg_set_bits   = '0;
    reg_reset_bits = '0;
    use_bsx        = 1'b0;
    load_stimulus();
    if (name_q.size() == 0)
      abort_run("The stimulus file holds no test lines");
    cycle_limit = 40 * name_q.size() + 100;
    repeat (2) @(posedge clkin);
    rst_n <= 1'b1;
    repeat (2) @(posedge clkin);
    foreach (op_q[i]) begin
      case (op_q[i])
        "W": bus_write(use_q[i], addr_q[i], data_q[i]);
        "R": bus_read(name_q[i], use_q[i], addr_q[i], exp_q[i][7:0]);
        "P": pgm_pulse(use_q[i], addr_q[i], data_q[i], exp_q[i][7:0]);
        "G": check_regs(name_q[i], exp_q[i][14:0]);
        "O": check_override(name_q[i], use_q[i], addr_q[i], exp_q[i][1:0]);
        default: abort_run($sformatf("Unknown operation %0s in test %0s", op_q[i], name_q[i]));
      endcase
    end
    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: verif/bsx_assertions.sv
`timescale 1ns/1ps
`include "bsx_cfg.svh"

module bsx_assertions (
  input logic                   clkin,
  input logic                   rst_n,
  input logic                   use_bsx,
  input logic [`BSX_ADDR_W-1:0] snes_addr,
  input logic                   data_ovr,
  input logic                   flash_writable,
  input logic                   rd_ev,
  input logic [`BSX_DATA_W-1:0] reg_data_out
);

  // Mapper off, no override outside the flash bank
  ovr_needs_bsx: assert property (@(posedge clkin) disable iff (!rst_n)
    (!use_bsx && snes_addr[23:16] != 8'hC0) |-> !data_ovr)
    else $error("data_ovr high with use_bsx low outside the flash bank");

  // Writable flash is never overridden
  writable_no_ovr: assert property (@(posedge clkin) disable iff (!rst_n)
    flash_writable |-> !data_ovr)
    else $error("flash_writable and data_ovr high together");

  // Read data only moves on the clock after a read event
  rdata_after_rd: assert property (@(posedge clkin) disable iff (!rst_n)
    (reg_data_out != $past(reg_data_out)) |-> $past(rd_ev))
    else $error("reg_data_out changed without a read event");

endmodule

bind bsx bsx_assertions u_assert (
  .clkin          (clkin),
  .rst_n          (rst_n),
  .use_bsx        (use_bsx),
  .snes_addr      (snes_addr),
  .data_ovr       (data_ovr),
  .flash_writable (flash_writable),
  .rd_ev          (rd_ev),
  .reg_data_out   (reg_data_out)
);

// File: logic/bsx.sv
`timescale 1ns/1ps
`include "bsx_cfg.svh"

module bsx (
  input  logic                   clkin,
  input  logic                   rst_n,
  input  logic                   reg_oe,
  input  logic                   reg_we,
  input  logic                   pgm_we,
  input  logic [`BSX_ADDR_W-1:0] snes_addr,
  input  logic [`BSX_DATA_W-1:0] reg_data_in,
  input  logic [`BSX_DATA_W-1:0] reg_set_bits,
  input  logic [`BSX_DATA_W-1:0] reg_reset_bits,
  input  logic                   use_bsx,
  output logic [`BSX_DATA_W-1:0] reg_data_out,
  output logic [`BSX_REGS_W-1:0] regs_out,
  output logic                   data_ovr,
  output logic                   flash_writable
);

  import bsx_pkg::*;

  logic                   rd_ev;
  logic                   wr_ev;
  logic                   pgm_ev;
  bsx_region_e            region;
  flash_mode_e            flash_mode;
  logic [3:0]             reg_idx;
  logic [4:0]             base_idx;
  logic [15:0]            flash_addr;
  logic                   cart_rbit;
  logic [`BSX_DATA_W-1:0] base_rdata;
  logic [`BSX_DATA_W-1:0] flash_rdata;

  strobe_sync u_sync (
    .clkin  (clkin),
    .rst_n  (rst_n),
    .reg_oe (reg_oe),
    .reg_we (reg_we),
    .pgm_we (pgm_we),
    .rd_ev  (rd_ev),
    .wr_ev  (wr_ev),
    .pgm_ev (pgm_ev)
  );

  bsx_decode u_decode (
    .snes_addr      (snes_addr),
    .use_bsx        (use_bsx),
    .flash_mode     (flash_mode),
    .region         (region),
    .reg_idx        (reg_idx),
    .base_idx       (base_idx),
    .flash_addr     (flash_addr),
    .flash_special  (),
    .data_ovr       (data_ovr),
    .flash_writable (flash_writable)
  );

  bsx_cart_regs u_cart (
    .clkin          (clkin),
    .rst_n          (rst_n),
    .pgm_ev         (pgm_ev),
    .wr_ev          (wr_ev),
    .region         (region),
    .reg_idx        (reg_idx),
    .reg_data_in    (reg_data_in),
    .reg_set_bits   (reg_set_bits),
    .reg_reset_bits (reg_reset_bits),
    .regs_out       (regs_out),
    .cart_rbit      (cart_rbit)
  );

  bsx_base_regs u_base (
    .clkin       (clkin),
    .rst_n       (rst_n),
    .rd_ev       (rd_ev),
    .wr_ev       (wr_ev),
    .region      (region),
    .base_idx    (base_idx),
    .reg_data_in (reg_data_in),
    .base_rdata  (base_rdata)
  );

  bsx_flash_cmd u_flash (
    .clkin       (clkin),
    .rst_n       (rst_n),
    .wr_ev       (wr_ev),
    .region      (region),
    .flash_addr  (flash_addr),
    .reg_data_in (reg_data_in),
    .flash_mode  (flash_mode),
    .flash_rdata (flash_rdata)
  );

  bsx_read_mux u_rmux (
    .clkin        (clkin),
    .rst_n        (rst_n),
    .rd_ev        (rd_ev),
    .region       (region),
    .cart_rbit    (cart_rbit),
    .base_rdata   (base_rdata),
    .flash_rdata  (flash_rdata),
    .reg_data_out (reg_data_out)
  );

endmodule

// File: logic/bsx_read_mux.sv
`timescale 1ns/1ps
`include "bsx_cfg.svh"

module bsx_read_mux (
  input  logic                   clkin,
  input  logic                   rst_n,
  input  logic                   rd_ev,
  input  bsx_pkg::bsx_region_e   region,
  input  logic                   cart_rbit,
  input  logic [`BSX_DATA_W-1:0] base_rdata,
  input  logic [`BSX_DATA_W-1:0] flash_rdata,
  output logic [`BSX_DATA_W-1:0] reg_data_out
);

  import bsx_pkg::*;

  always_ff @(posedge clkin or negedge rst_n) begin
    if (!rst_n) begin
      reg_data_out <= '0;
    end else if (rd_ev) begin
      case (region)
        REGION_CART:  reg_data_out <= {cart_rbit, {(`BSX_DATA_W-1){1'b0}}};
        REGION_BASE:  reg_data_out <= base_rdata;
        REGION_FLASH: reg_data_out <= flash_rdata;
        // Unmapped read keeps the last byte
        default:      reg_data_out <= reg_data_out;
      endcase
    end
  end

endmodule

// File: logic/bsx_flash_cmd.sv
`timescale 1ns/1ps
`include "bsx_cfg.svh"

module bsx_flash_cmd (
  input  logic                   clkin,
  input  logic                   rst_n,
  input  logic                   wr_ev,
  input  bsx_pkg::bsx_region_e   region,
  input  logic [15:0]            flash_addr,
  input  logic [`BSX_DATA_W-1:0] reg_data_in,
  output bsx_pkg::flash_mode_e   flash_mode,
  output logic [`BSX_DATA_W-1:0] flash_rdata
);

  import bsx_pkg::*;

  flash_mode_e mode_q;
  logic [7:0]  cmd0;
  logic [15:0] cmd_unlock;
  logic        flash_wr;

  function automatic logic [7:0] vendor_byte(input logic [2:0] idx);
    case (idx)
      3'd0:    vendor_byte = 8'h4D;
      3'd2:    vendor_byte = 8'h50;
      3'd6:    vendor_byte = 8'h2A;
      default: vendor_byte = 8'h00;
    endcase
  endfunction

  assign flash_wr = wr_ev && (region == REGION_FLASH);

  ////////////////////////////////////////////////////////////
  // Command sequence tracking
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clkin or negedge rst_n) begin
    if (!rst_n) begin
      mode_q     <= FLASH_READ;
      cmd0       <= '0;
      cmd_unlock <= '0;
    end else if (flash_wr) begin
      case (flash_addr)
        16'h0000: begin
          cmd0 <= reg_data_in;
          // Status read entry, 38 then D0
          if (cmd0 == 8'h38 && reg_data_in == 8'hD0 && mode_q == FLASH_READ)
            mode_q <= FLASH_STATUS;
        end
        16'h5555: begin
          cmd_unlock <= {cmd_unlock[7:0], reg_data_in};
          if (cmd_unlock == 16'hAA55) begin
            case (reg_data_in)
              8'hF0: mode_q <= FLASH_READ;
              8'hA0: mode_q <= FLASH_PROGRAM;
              8'h70: begin
                if (mode_q == FLASH_PROGRAM)
                  mode_q <= FLASH_STATUS;
              end
              default: mode_q <= mode_q;
            endcase
          end
        end
        16'h2AAA: cmd_unlock <= {cmd_unlock[7:0], reg_data_in};
        default: cmd0 <= cmd0;
      endcase
    end
  end

  assign flash_mode = mode_q;

  // Status and ID reads
  always_comb begin
    if (flash_addr == 16'h0002 || flash_addr == 16'h5555)
      flash_rdata = 8'h80;
    else if (flash_addr[15:3] == 13'h1FE0)
      flash_rdata = vendor_byte(flash_addr[2:0]);
    else
      flash_rdata = 8'h00;
  end

endmodule

// File: logic/bsx_base_regs.sv
`timescale 1ns/1ps
`include "bsx_cfg.svh"

module bsx_base_regs (
  input  logic                   clkin,
  input  logic                   rst_n,
  input  logic                   rd_ev,
  input  logic                   wr_ev,
  input  bsx_pkg::bsx_region_e   region,
  input  logic [4:0]             base_idx,
  input  logic [`BSX_DATA_W-1:0] reg_data_in,
  output logic [`BSX_DATA_W-1:0] base_rdata
);

  import bsx_pkg::*;

  localparam int CNT_W = $clog2(`BSX_STREAM_LEN + 1);

  logic [`BSX_DATA_W-1:0] base_q [`BSX_BASE_LO:`BSX_BASE_HI];
  logic [CNT_W-1:0]       stream_cnt;
  logic                   base_rd;
  logic                   base_wr;

  function automatic logic [7:0] base_default(input logic [4:0] idx);
    case (idx)
      5'h0B, 5'h0D, 5'h11: base_default = 8'h9F;
      5'h0C:               base_default = 8'h10;
      5'h12:               base_default = 8'h01;
      5'h16:               base_default = 8'h02;
      5'h17:               base_default = 8'hFF;
      5'h18:               base_default = 8'h80;
      5'h19:               base_default = 8'h01;
      default:             base_default = 8'h00;
    endcase
  endfunction

  // Fixed byte pattern of the receive stream
  function automatic logic [7:0] stream_byte(input logic [CNT_W-1:0] cnt);
    case (cnt)
      5, 6:    stream_byte = 8'h01;
      10:      stream_byte = 8'h2A;
      11:      stream_byte = 8'h1E;
      12:      stream_byte = 8'h12;
      default: stream_byte = 8'h00;
    endcase
  endfunction

  assign base_rd = rd_ev && (region == REGION_BASE);
  assign base_wr = wr_ev && (region == REGION_BASE);

  ////////////////////////////////////////////////////////////
  // Read data
  ////////////////////////////////////////////////////////////

  always_comb begin
    if (base_idx < `BSX_BASE_LO)
      base_rdata = '0;
    else if (base_idx == 5'h12)
      base_rdata = (stream_cnt < `BSX_STREAM_LEN) ? stream_byte(stream_cnt) : 8'h00;
    else if (base_idx == 5'h13)
      base_rdata = base_q[base_idx] & 8'h3F;
    else
      base_rdata = base_q[base_idx];
  end

  ////////////////////////////////////////////////////////////
  // Register file and stream counter
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clkin or negedge rst_n) begin
    if (!rst_n) begin
      stream_cnt <= '0;
      for (int i = `BSX_BASE_LO; i <= `BSX_BASE_HI; i++)
        base_q[i] <= base_default(5'(i));
    end else if (base_rd) begin
      if (base_idx == 5'h12) begin
        if (stream_cnt < `BSX_STREAM_LEN)
          stream_cnt <= stream_cnt + 1'b1;
        else
          stream_cnt <= '0;
      end
    end else if (base_wr && base_idx >= `BSX_BASE_LO) begin
      case (base_idx)
        5'h11: begin
          stream_cnt     <= '0;
          base_q[5'h11]  <= reg_data_in;
        end
        // Write data is ignored here
        5'h0F: begin
          base_q[5'h0E] <= base_q[5'h0F] - (base_q[5'h0E] >> 1);
          base_q[5'h0F] <= base_q[5'h0F] >> 1;
        end
        default: base_q[base_idx] <= reg_data_in;
      endcase
    end
  end

endmodule

// File: logic/bsx_cart_regs.sv
`timescale 1ns/1ps
`include "bsx_cfg.svh"

module bsx_cart_regs (
  input  logic                   clkin,
  input  logic                   rst_n,
  input  logic                   pgm_ev,
  input  logic                   wr_ev,
  input  bsx_pkg::bsx_region_e   region,
  input  logic [3:0]             reg_idx,
  input  logic [`BSX_DATA_W-1:0] reg_data_in,
  input  logic [`BSX_DATA_W-1:0] reg_set_bits,
  input  logic [`BSX_DATA_W-1:0] reg_reset_bits,
  output logic [`BSX_REGS_W-1:0] regs_out,
  output logic                   cart_rbit
);

  import bsx_pkg::*;

  // Commit forces the top mapper bit on
  localparam logic [`BSX_REGS_W-1:0] COMMIT_BIT = 15'h4000;

  logic [`BSX_REGS_W-1:0] regs_stage;
  logic [`BSX_REGS_W-1:0] regs_live;
  logic                   cart_wr;

  assign cart_wr = wr_ev && (region == REGION_CART);

  always_ff @(posedge clkin or negedge rst_n) begin
    if (!rst_n) begin
      regs_stage <= `BSX_REGS_INIT;
      regs_live  <= `BSX_REGS_INIT;
    end else if (pgm_ev) begin
      // Reset mask applied after set mask, so reset wins
      regs_stage[8:1] <= (regs_stage[8:1] | reg_set_bits) & ~reg_reset_bits;
      regs_live[8:1]  <= (regs_live[8:1] | reg_set_bits) & ~reg_reset_bits;
    end else if (cart_wr) begin
      if (reg_idx == 4'hE && reg_data_in[7])
        regs_live <= regs_stage | COMMIT_BIT;
      else if (reg_idx != 4'hF)
        regs_stage[reg_idx] <= reg_data_in[7];
    end
  end

  assign regs_out  = regs_live;
  assign cart_rbit = (reg_idx == 4'hF) ? 1'b0 : regs_live[reg_idx];

endmodule

// File: logic/bsx_decode.sv
`timescale 1ns/1ps
`include "bsx_cfg.svh"

module bsx_decode (
  input  logic [`BSX_ADDR_W-1:0] snes_addr,
  input  logic                   use_bsx,
  input  bsx_pkg::flash_mode_e   flash_mode,
  output bsx_pkg::bsx_region_e   region,
  output logic [3:0]             reg_idx,
  output logic [4:0]             base_idx,
  output logic [15:0]            flash_addr,
  output logic                   flash_special,
  output logic                   data_ovr,
  output logic                   flash_writable
);

  import bsx_pkg::*;

  logic [15:0] low_addr;
  logic        cart_hit;
  logic        base_hit;
  logic        flash_hit;

  assign low_addr = snes_addr[15:0];

  ////////////////////////////////////////////////////////////
  // Window decode
  ////////////////////////////////////////////////////////////

  // Banks 00-0F, page 5
  assign cart_hit = use_bsx && ((snes_addr[23:12] & 12'hF0F) == 12'h005);

  assign base_hit = use_bsx && !snes_addr[22] &&
                    (low_addr >= 16'h2188) && (low_addr <= 16'h219F);

  // Flash bank is decoded even with the mapper off
  assign flash_hit = (snes_addr[23:16] == 8'hC0);

  always_comb begin
    if (cart_hit)
      region = REGION_CART;
    else if (base_hit)
      region = REGION_BASE;
    else if (flash_hit)
      region = REGION_FLASH;
    else
      region = REGION_NONE;
  end

  assign reg_idx    = snes_addr[19:16];
  assign base_idx   = snes_addr[4:0];
  assign flash_addr = low_addr;

  assign flash_special = (low_addr == 16'h0000) || (low_addr == 16'h0002) ||
                         (low_addr == 16'h2AAA) || (low_addr == 16'h5555) ||
                         ((low_addr >= 16'hFF00) && (low_addr <= 16'hFF13));

  ////////////////////////////////////////////////////////////
  // Bus override and flash write enable
  ////////////////////////////////////////////////////////////

  assign data_ovr = (use_bsx && (region == REGION_CART)) ||
                    (use_bsx && (region == REGION_BASE)) ||
                    (use_bsx && (region == REGION_FLASH) && flash_special &&
                     (flash_mode != FLASH_READ));

  assign flash_writable = use_bsx && (region == REGION_FLASH) &&
                          (flash_mode == FLASH_PROGRAM) && !flash_special;

endmodule

// File: logic/strobe_sync.sv
`timescale 1ns/1ps
`include "bsx_cfg.svh"

module strobe_sync (
  input  logic clkin,
  input  logic rst_n,
  input  logic reg_oe,
  input  logic reg_we,
  input  logic pgm_we,
  output logic rd_ev,
  output logic wr_ev,
  output logic pgm_ev
);

  localparam int OE_LEN = `BSX_OE_SYNC_LEN;
  localparam int WE_LEN = `BSX_WE_SYNC_LEN;

  // One high sample, then all low
  localparam logic [OE_LEN-1:0] OE_FALL = {1'b1, {(OE_LEN-1){1'b0}}};
  // All low, then one high sample
  localparam logic [WE_LEN-1:0] WE_RISE = {{(WE_LEN-1){1'b0}}, 1'b1};

  logic [OE_LEN-1:0] oe_hist;
  logic [WE_LEN-1:0] we_hist;
  logic [WE_LEN-1:0] pgm_hist;
  logic              oe_fall;
  logic              we_rise;
  logic              pgm_rise;

  always_ff @(posedge clkin or negedge rst_n) begin
    if (!rst_n) begin
      oe_hist  <= '0;
      we_hist  <= '0;
      pgm_hist <= '0;
    end else begin
      oe_hist  <= {oe_hist[OE_LEN-2:0], reg_oe};
      we_hist  <= {we_hist[WE_LEN-2:0], reg_we};
      pgm_hist <= {pgm_hist[WE_LEN-2:0], pgm_we};
    end
  end

  assign oe_fall  = (oe_hist == OE_FALL);
  assign we_rise  = (we_hist == WE_RISE);
  assign pgm_rise = (pgm_hist == WE_RISE);

  // Read wins, then program, then write; losers are dropped
  assign rd_ev  = oe_fall;
  assign pgm_ev = pgm_rise & ~oe_fall;
  assign wr_ev  = we_rise & ~oe_fall & ~pgm_rise;

endmodule

// File: logic/bsx_pkg.sv
package bsx_pkg;

  // Window hit by the current bus address
  typedef enum logic [1:0] {
    REGION_NONE  = 2'd0,
    REGION_CART  = 2'd1,
    REGION_BASE  = 2'd2,
    REGION_FLASH = 2'd3
  } bsx_region_e;

  // Flash chip command mode
  typedef enum logic [1:0] {
    FLASH_READ    = 2'd0,
    FLASH_STATUS  = 2'd1,
    FLASH_PROGRAM = 2'd2
  } flash_mode_e;

endpackage

// File: logic/bsx_cfg.svh
`ifndef BSX_CFG_SVH
`define BSX_CFG_SVH

// Bus widths
`define BSX_ADDR_W 24
`define BSX_DATA_W 8

// Mapper configuration
`define BSX_REGS_W 15
`define BSX_REGS_INIT 15'h0100

// Strobe filter lengths
`define BSX_OE_SYNC_LEN 6
`define BSX_WE_SYNC_LEN 2

// Stream counter wrap
`define BSX_STREAM_LEN 18

// Base register file index range
`define BSX_BASE_LO 8
`define BSX_BASE_HI 31

`endif
